//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+include
rtl/cpu_pkg.sv
rtl/core_ctrl.sv
rtl/decode.sv
rtl/reg_file.sv
rtl/execute.sv
rtl/result.sv
rtl/mycpu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_XLEN 32

// first fetch address after reset
`define CPU_RESET_PC 32'hbfc0_0000

// general purpose registers
`define CPU_REG_NUM 32

`endif

//--- rtl/core_ctrl.sv
`include "cpu_defs.svh"

module core_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_XLEN-1:0]   inst_sram_rdata,
    input  logic                   mem_done,
    input  logic                   branch_taken,
    input  logic [15:0]            branch_imm,
    input  cpu_pkg::instr_op_e     op,
    output logic                   inst_sram_en,
    output logic [`CPU_XLEN-1:0]   inst_sram_addr,
    output logic [`CPU_XLEN-1:0]   instr,
    output logic [`CPU_XLEN-1:0]   pc,
    output cpu_pkg::cpu_state_e    state
);
    import cpu_pkg::*;

    cpu_state_e           next_state;
    logic [`CPU_XLEN-1:0] branch_off;

    always_comb begin
        next_state = state;
        case (state)
            // wait one slot after reset until the fetch request is out
            S_FETCH:  next_state = inst_sram_en ? S_DECODE : S_FETCH;
            S_DECODE: next_state = S_EXEC;
            S_EXEC:   next_state = (op == OP_LW || op == OP_SW) ? S_MEM : S_WB;
            S_MEM:    next_state = mem_done ? S_WB : S_MEM;
            S_WB:     next_state = S_FETCH;
            default:  next_state = S_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_FETCH;
            inst_sram_en <= 1'b0;
        end else begin
            state        <= next_state;
            inst_sram_en <= (next_state == S_FETCH);
        end
    end

    // sram data arrives the cycle after the request
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            instr <= inst_sram_rdata;
        end
    end

    assign branch_off = branch_taken ?
                        {{(`CPU_XLEN-18){branch_imm[15]}}, branch_imm, 2'b00} : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (state == S_WB) begin
            pc <= pc + `CPU_XLEN'd4 + branch_off;
        end
    end

    assign inst_sram_addr = pc;

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // one instruction in flight, memory state only for lw/sw
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB
    } cpu_state_e;

    typedef enum logic [3:0] {
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_SLT,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_INVALID
    } instr_op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

//--- rtl/decode.sv
`include "cpu_defs.svh"

module decode (
    input  logic [`CPU_XLEN-1:0] instr,
    output cpu_pkg::instr_op_e   op,
    output cpu_pkg::alu_op_e     alu_op,
    output logic [4:0]           rs,
    output logic [4:0]           rt,
    output logic [4:0]           wnum,
    output logic [`CPU_XLEN-1:0] imm_ext,
    output logic                 use_imm
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    always_comb begin
        op = OP_INVALID;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h21:   op = OP_ADDU;
                    6'h23:   op = OP_SUBU;
                    6'h24:   op = OP_AND;
                    6'h25:   op = OP_OR;
                    6'h2a:   op = OP_SLT;
                    default: op = OP_INVALID;
                endcase
            end
            6'h09:   op = OP_ADDIU;
            6'h0d:   op = OP_ORI;
            6'h0f:   op = OP_LUI;
            6'h23:   op = OP_LW;
            6'h2b:   op = OP_SW;
            6'h04:   op = OP_BEQ;
            default: op = OP_INVALID;
        endcase
    end

    always_comb begin
        case (op)
            OP_SUBU, OP_BEQ: alu_op = ALU_SUB;
            OP_AND:          alu_op = ALU_AND;
            OP_OR, OP_ORI:   alu_op = ALU_OR;
            OP_SLT:          alu_op = ALU_SLT;
            OP_LUI:          alu_op = ALU_LUI;
            default:         alu_op = ALU_ADD;
        endcase
    end

    assign use_imm = (op == OP_ADDIU) || (op == OP_ORI) || (op == OP_LUI) ||
                     (op == OP_LW) || (op == OP_SW);

    // r-type writes rd, the rest write rt
    assign wnum = (opcode == 6'h00) ? instr[15:11] : rt;

    // ori is the only zero-extended immediate
    assign imm_ext = (op == OP_ORI) ? {{(`CPU_XLEN-16){1'b0}}, instr[15:0]} :
                                      {{(`CPU_XLEN-16){instr[15]}}, instr[15:0]};

endmodule

//--- rtl/execute.sv
`include "cpu_defs.svh"

module execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_pkg::cpu_state_e  state,
    input  cpu_pkg::alu_op_e     alu_op,
    input  cpu_pkg::instr_op_e   op,
    input  logic                 use_imm,
    input  logic [`CPU_XLEN-1:0] rdata1,
    input  logic [`CPU_XLEN-1:0] rdata2,
    input  logic [`CPU_XLEN-1:0] imm_ext,
    output logic [`CPU_XLEN-1:0] alu_result,
    output logic [`CPU_XLEN-1:0] store_data,
    output logic                 branch_taken
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] src_b;
    logic [`CPU_XLEN-1:0] alu_out;

    assign src_b = use_imm ? imm_ext : rdata2;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_out = rdata1 - src_b;
            ALU_AND: alu_out = rdata1 & src_b;
            ALU_OR:  alu_out = rdata1 | src_b;
            ALU_SLT: alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(rdata1) < $signed(src_b)};
            ALU_LUI: alu_out = src_b << 16;
            default: alu_out = rdata1 + src_b;
        endcase
    end

    // also the load/store address
    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            alu_result <= alu_out;
            store_data <= rdata2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_taken <= 1'b0;
        end else if (state == S_EXEC) begin
            branch_taken <= (op == OP_BEQ) && (rdata1 == rdata2);
        end
    end

endmodule

//--- rtl/mycpu_top.sv
`include "cpu_defs.svh"

module mycpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 inst_sram_en,
    output logic [31:0]          inst_sram_addr,
    input  logic [31:0]          inst_sram_rdata,
    output logic                 data_sram_en,
    output logic [3:0]           data_sram_wen,
    output logic [31:0]          data_sram_addr,
    output logic [31:0]          data_sram_wdata,
    input  logic [31:0]          data_sram_rdata,
    input  logic                 data_sram_data_ok,
    output logic [31:0]          debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [31:0]          debug_wb_rf_wdata
);
    import cpu_pkg::*;

    cpu_state_e           state;
    instr_op_e            op;
    alu_op_e              alu_op;
    logic [`CPU_XLEN-1:0] instr;
    logic [`CPU_XLEN-1:0] pc;
    logic [4:0]           rs;
    logic [4:0]           rt;
    logic [4:0]           wnum;
    logic [`CPU_XLEN-1:0] imm_ext;
    logic                 use_imm;
    logic [`CPU_XLEN-1:0] rdata1;
    logic [`CPU_XLEN-1:0] rdata2;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] store_data;
    logic                 branch_taken;
    logic                 mem_done;
    logic                 rf_we;
    logic [4:0]           rf_waddr;
    logic [`CPU_XLEN-1:0] rf_wdata;

    core_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_sram_rdata (inst_sram_rdata),
        .mem_done        (mem_done),
        .branch_taken    (branch_taken),
        .branch_imm      (imm_ext[15:0]),
        .op              (op),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .instr           (instr),
        .pc              (pc),
        .state           (state)
    );

    decode u_decode (
        .instr   (instr),
        .op      (op),
        .alu_op  (alu_op),
        .rs      (rs),
        .rt      (rt),
        .wnum    (wnum),
        .imm_ext (imm_ext),
        .use_imm (use_imm)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    execute u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .alu_op       (alu_op),
        .op           (op),
        .use_imm      (use_imm),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .imm_ext      (imm_ext),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .branch_taken (branch_taken)
    );

    result u_result (
        .clk               (clk),
        .rst_n             (rst_n),
        .state             (state),
        .op                (op),
        .wnum              (wnum),
        .pc                (pc),
        .alu_result        (alu_result),
        .store_data        (store_data),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .data_sram_data_ok (data_sram_data_ok),
        .mem_done          (mem_done),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- rtl/reg_file.sv
`include "cpu_defs.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [4:0]           raddr1,
    input  logic [4:0]           raddr2,
    output logic [`CPU_XLEN-1:0] rdata1,
    output logic [`CPU_XLEN-1:0] rdata2,
    input  logic                 we,
    input  logic [4:0]           waddr,
    input  logic [`CPU_XLEN-1:0] wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- rtl/result.sv
`include "cpu_defs.svh"

module result (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_pkg::cpu_state_e  state,
    input  cpu_pkg::instr_op_e   op,
    input  logic [4:0]           wnum,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_XLEN-1:0] alu_result,
    input  logic [`CPU_XLEN-1:0] store_data,
    output logic                 data_sram_en,
    output logic [3:0]           data_sram_wen,
    output logic [`CPU_XLEN-1:0] data_sram_addr,
    output logic [`CPU_XLEN-1:0] data_sram_wdata,
    input  logic [`CPU_XLEN-1:0] data_sram_rdata,
    input  logic                 data_sram_data_ok,
    output logic                 mem_done,
    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [`CPU_XLEN-1:0] rf_wdata,
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] load_data;
    logic                 writes_reg;

    // request goes out with S_MEM and is held until data_ok
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_sram_en  <= 1'b0;
            data_sram_wen <= 4'h0;
        end else if (state == S_EXEC && (op == OP_LW || op == OP_SW)) begin
            data_sram_en  <= 1'b1;
            data_sram_wen <= (op == OP_SW) ? 4'hf : 4'h0;
        end else if (mem_done) begin
            data_sram_en  <= 1'b0;
            data_sram_wen <= 4'h0;
        end
    end

    assign mem_done        = data_sram_en & data_sram_data_ok;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data;

    always_ff @(posedge clk) begin
        if (mem_done) begin
            load_data <= data_sram_rdata;
        end
    end

    always_comb begin
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT,
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: writes_reg = 1'b1;
            default:                          writes_reg = 1'b0;
        endcase
    end

    assign rf_we    = (state == S_WB) && writes_reg && (wnum != 5'd0);
    assign rf_waddr = wnum;
    assign rf_wdata = (op == OP_LW) ? load_data : alu_result;

    // debug port mirrors the register write
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- sim/tb_checker.sv
`include "cpu_defs.svh"

module tb_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] prog [256],
    input  logic [31:0] dmem_init [256],
    input  logic        inst_sram_en,
    input  logic [31:0] inst_sram_addr,
    input  logic        data_sram_en,
    input  logic [3:0]  data_sram_wen,
    input  logic [31:0] data_sram_addr,
    input  logic [31:0] data_sram_wdata,
    input  logic        data_sram_data_ok,
    input  logic [31:0] debug_wb_pc,
    input  logic [3:0]  debug_wb_rf_wen,
    input  logic [4:0]  debug_wb_rf_wnum,
    input  logic [31:0] debug_wb_rf_wdata,
    output logic        done,
    output int          errors
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int T_RESET = 0;
    localparam int T_ALU   = 1;
    localparam int T_MEM   = 2;
    localparam int T_BR    = 3;
    localparam int T_R0    = 4;
    localparam int T_DONE  = 5;
    localparam int WB_WAIT = 50;
    localparam logic [31:0] STOP_WORD = {6'h04, 10'h0, 16'hffff};

    string       names [6] = '{"reset", "alu", "load_store", "branch", "reg0", "completion"};
    int          checks [6];
    int          errs [6];
    logic [31:0] regs [`CPU_REG_NUM];
    logic [31:0] dmem [256];
    logic        exp_mem;
    logic        exp_store;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic        saw_access;
    logic        p_ien;
    logic        p_den;
    logic        p_dok;
    logic [3:0]  p_dwen;
    logic [31:0] p_daddr;
    logic [31:0] p_dwdata;
    logic [31:0] p_pc;
    logic [3:0]  p_wen;
    logic [4:0]  p_wnum;
    logic [31:0] p_wdata;
    logic [31:0] r_pc;
    logic [3:0]  r_wen;
    logic [4:0]  r_wnum;
    logic [31:0] r_wdata;
    logic [31:0] r_iaddr;
    int          dut_writes;
    int          model_writes;

    task automatic check_val(input int t, input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            errs[t]++;
            $display("ERROR time %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_fail(input int t, input string msg);
        errs[t]++;
        $display("time %0t: %s", $time, msg);
    endtask

    // one write-back slot is the cycle before the next fetch request
    task automatic wait_retire(output logic got);
        got = 1'b0;
        for (int i = 0; i < WB_WAIT && !got; i++) begin
            @(posedge clk);
            if (p_den && !p_dok) begin
                check_val(T_MEM, "data_sram_en held", 32'h1, {31'h0, data_sram_en});
                check_val(T_MEM, "data_sram_addr held", p_daddr, data_sram_addr);
                check_val(T_MEM, "data_sram_wen held", {28'h0, p_dwen}, {28'h0, data_sram_wen});
                check_val(T_MEM, "data_sram_wdata held", p_dwdata, data_sram_wdata);
            end
            if (data_sram_en && data_sram_data_ok) begin
                saw_access = 1'b1;
                if (!exp_mem) begin
                    report_fail(T_MEM, "data SRAM access by an instruction without memory");
                end else begin
                    check_val(T_MEM, "data_sram_addr", exp_addr, data_sram_addr);
                    check_val(T_MEM, "data_sram_wen", exp_store ? 32'hf : 32'h0,
                              {28'h0, data_sram_wen});
                    if (exp_store) begin
                        check_val(T_MEM, "data_sram_wdata", exp_wdata, data_sram_wdata);
                    end
                end
            end
            // every cycle with the write enable up counts, not only the slot
            if (debug_wb_rf_wen != 4'h0) begin
                dut_writes++;
            end
            if (inst_sram_en && !p_ien) begin
                got     = 1'b1;
                r_pc    = p_pc;
                r_wen   = p_wen;
                r_wnum  = p_wnum;
                r_wdata = p_wdata;
                r_iaddr = inst_sram_addr;
            end
            p_ien    = inst_sram_en;
            p_den    = data_sram_en;
            p_dok    = data_sram_data_ok;
            p_dwen   = data_sram_wen;
            p_daddr  = data_sram_addr;
            p_dwdata = data_sram_wdata;
            p_pc     = debug_wb_pc;
            p_wen    = debug_wb_rf_wen;
            p_wnum   = debug_wb_rf_wnum;
            p_wdata  = debug_wb_rf_wdata;
        end
    endtask

    initial begin
        logic        fetched;
        logic        got;
        logic        stop;
        logic        prev_beq;
        logic        wr;
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] val;
        logic [31:0] idx;
        logic [4:0]  dest;
        int          cat;
        int          total;
        done         = 1'b0;
        errors       = 0;
        dut_writes   = 0;
        model_writes = 0;
        fetched      = 1'b0;
        stop         = 1'b0;
        prev_beq     = 1'b0;
        for (int t = 0; t < 6; t++) begin
            checks[t] = 0;
            errs[t]   = 0;
        end
        for (int i = 0; i < 40 && !fetched; i++) begin
            @(posedge clk);
            if (inst_sram_en) begin
                fetched = 1'b1;
                if (!rst_n) begin
                    report_fail(T_RESET, "instruction fetch while reset is asserted");
                end
                check_val(T_RESET, "inst_sram_addr", `CPU_RESET_PC, inst_sram_addr);
            end else begin
                check_val(T_RESET, "data_sram_en", 32'h0, {31'h0, data_sram_en});
                check_val(T_RESET, "debug_wb_rf_wen", 32'h0, {28'h0, debug_wb_rf_wen});
            end
        end
        if (!fetched) begin
            report_fail(T_RESET, "no instruction fetch within 40 cycles of start");
        end
        $display("test %s: %0d checks, %0d errors", names[T_RESET], checks[T_RESET],
                 errs[T_RESET]);
        for (int i = 0; i < 256; i++) begin
            dmem[i] = dmem_init[i];
        end
        for (int i = 0; i < `CPU_REG_NUM; i++) begin
            regs[i] = '0;
        end
        p_ien = 1'b1;
        p_den = 1'b0;
        p_dok = 1'b0;
        pc    = `CPU_RESET_PC;
        for (int n = 0; n < 1000 && fetched && !stop; n++) begin
            idx       = (pc - `CPU_RESET_PC) >> 2;
            w         = (idx < 256) ? prog[idx[7:0]] : STOP_WORD;
            a         = regs[w[25:21]];
            b         = regs[w[20:16]];
            sx        = {{16{w[15]}}, w[15:0]};
            npc       = pc + 32'd4;
            wr        = 1'b0;
            dest      = w[20:16];
            val       = '0;
            cat       = T_ALU;
            exp_mem   = 1'b0;
            exp_store = 1'b0;
            case (w[31:26])
                6'h00: begin
                    dest = w[15:11];
                    wr   = 1'b1;
                    case (w[5:0])
                        6'h21:   val = a + b;
                        6'h23:   val = a - b;
                        6'h24:   val = a & b;
                        6'h25:   val = a | b;
                        6'h2a:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: begin
                    wr  = 1'b1;
                    val = a + sx;
                end
                6'h0d: begin
                    wr  = 1'b1;
                    val = a | {16'h0, w[15:0]};
                end
                6'h0f: begin
                    wr  = 1'b1;
                    val = {w[15:0], 16'h0};
                end
                6'h23: begin
                    cat      = T_MEM;
                    exp_mem  = 1'b1;
                    exp_addr = a + sx;
                    wr       = 1'b1;
                    val      = dmem[exp_addr[9:2]];
                end
                6'h2b: begin
                    cat       = T_MEM;
                    exp_mem   = 1'b1;
                    exp_store = 1'b1;
                    exp_addr  = a + sx;
                    exp_wdata = b;
                end
                6'h04: begin
                    cat = T_BR;
                    if (a == b) begin
                        npc = pc + 32'd4 + {sx[29:0], 2'b00};
                    end
                end
                default: cat = T_ALU;
            endcase
            saw_access = 1'b0;
            wait_retire(got);
            if (!got) begin
                report_fail(T_DONE, "no write-back arrived within 50 cycles");
                break;
            end
            check_val(prev_beq ? T_BR : cat, "debug_wb_pc", pc, r_pc);
            check_val(cat, "inst_sram_addr", npc, r_iaddr);
            if (exp_mem && !saw_access) begin
                report_fail(T_MEM, "load or store finished without a data SRAM access");
            end
            if (wr && dest != 5'd0) begin
                check_val(cat, "debug_wb_rf_wen", 32'hf, {28'h0, r_wen});
                check_val(cat, "debug_wb_rf_wnum", {27'h0, dest}, {27'h0, r_wnum});
                check_val(cat, "debug_wb_rf_wdata", val, r_wdata);
                regs[dest] = val;
                model_writes++;
            end else begin
                check_val(wr ? T_R0 : cat, "debug_wb_rf_wen", 32'h0, {28'h0, r_wen});
            end
            if (exp_store) begin
                dmem[exp_addr[9:2]] = b;
            end
            stop     = (w == STOP_WORD);
            prev_beq = (w[31:26] == 6'h04);
            pc       = npc;
        end
        if (!stop) begin
            report_fail(T_DONE, "final instruction was never reached");
        end
        check_val(T_DONE, "write-back count", 32'(model_writes), 32'(dut_writes));
        total = checks[T_RESET];
        for (int t = T_ALU; t <= T_DONE; t++) begin
            $display("test %s: %0d checks, %0d errors", names[t], checks[t], errs[t]);
            total = total + checks[t];
        end
        for (int t = 0; t < 6; t++) begin
            errors = errors + errs[t];
        end
        $display("checks %0d, errors %0d, write-backs %0d", total, errors, dut_writes);
        done = 1'b1;
    end

endmodule

//--- sim/tb_top.sv
`include "cpu_defs.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED      = 32'hef9f_b668;
    localparam int          PROG_LEN  = 200;
    localparam int          MAX_DELAY = 4;
    localparam int          MEM_WORDS = 256;
    localparam int          RUN_LIMIT = 20000;
    // beq $0, $0, -1 spins forever
    localparam logic [31:0] STOP_WORD = {6'h04, 10'h0, 16'hffff};

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic        data_sram_data_ok;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] dmem_init [MEM_WORDS];
    logic [31:0] lcg_state;
    logic [31:0] iword;
    logic        busy;
    int          busy_cnt;
    logic        done;
    int          errors;
    int          cyc;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] gen_instr(int idx);
        logic [31:0] r;
        logic [31:0] k;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        int          off;
        r   = next_rand();
        k   = (r >> 16) % 32'd11;
        r   = next_rand();
        // few registers so results get reused, r0 included
        rs  = {2'b00, r[20:18]};
        rt  = {2'b00, r[23:21]};
        rd  = {2'b00, r[26:24]};
        r   = next_rand();
        imm = r[31:16];
        case (k)
            32'd0:   return {6'h00, rs, rt, rd, 5'h0, 6'h21};
            32'd1:   return {6'h00, rs, rt, rd, 5'h0, 6'h23};
            32'd2:   return {6'h00, rs, rt, rd, 5'h0, 6'h24};
            32'd3:   return {6'h00, rs, rt, rd, 5'h0, 6'h25};
            32'd4:   return {6'h00, rs, rt, rd, 5'h0, 6'h2a};
            32'd5:   return {6'h09, rs, rt, imm};
            32'd6:   return {6'h0d, rs, rt, imm};
            32'd7:   return {6'h0f, 5'd0, rt, imm};
            // 256-word window off r0
            32'd8:   return {6'h23, 5'd0, rt, 6'h0, imm[7:0], 2'b00};
            32'd9:   return {6'h2b, 5'd0, rt, 6'h0, imm[7:0], 2'b00};
            default: begin
                off = int'(imm[1:0]);
                if (off > PROG_LEN - 1 - idx) begin
                    off = PROG_LEN - 1 - idx;
                end
                return {6'h04, rs, rt, 16'(off)};
            end
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction sram, data one cycle after the request
    always @(posedge clk) begin
        if (inst_sram_en) begin
            iword = (inst_sram_addr - `CPU_RESET_PC) >> 2;
            #1;
            inst_sram_rdata = (iword < MEM_WORDS) ? imem[iword[7:0]] : STOP_WORD;
        end
    end

    // data sram with a random number of wait cycles
    always @(posedge clk) begin
        if (data_sram_en && data_sram_data_ok) begin
            if (data_sram_wen == 4'hf) begin
                dmem[data_sram_addr[9:2]] = data_sram_wdata;
            end
            busy = 1'b0;
        end
        #1;
        if (data_sram_en && !busy) begin
            busy     = 1'b1;
            busy_cnt = int'((next_rand() >> 16) % 32'(MAX_DELAY + 1));
        end else if (busy && busy_cnt > 0) begin
            busy_cnt = busy_cnt - 1;
        end
        data_sram_data_ok = data_sram_en && busy && (busy_cnt == 0);
        data_sram_rdata   = dmem[data_sram_addr[9:2]];
    end

    mycpu_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .data_sram_data_ok (data_sram_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_checker u_checker (
        .clk               (clk),
        .rst_n             (rst_n),
        .prog              (imem),
        .dmem_init         (dmem_init),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_data_ok (data_sram_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done              (done),
        .errors            (errors)
    );

    initial begin
        rst_n             = 1'b0;
        inst_sram_rdata   = '0;
        data_sram_rdata   = '0;
        data_sram_data_ok = 1'b0;
        busy              = 1'b0;
        busy_cnt          = 0;
        lcg_state         = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]      = (i < PROG_LEN) ? gen_instr(i) : STOP_WORD;
            dmem_init[i] = (32'(i) * 32'h9e37_79b9) ^ {~8'(i), 8'(i), 16'h5aa5};
            dmem[i]      = dmem_init[i];
        end
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        for (cyc = 0; cyc < RUN_LIMIT && !done; cyc++) begin
            @(posedge clk);
        end
        if (!done) begin
            $display("checker did not finish within %0d cycles", RUN_LIMIT);
            $display("Result: FAILED");
        end else if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
